// ==== filelist.f ====
hdl/fps_cfg_pkg.sv
hdl/fps_ctrl_pkg.sv
hdl/fps_ctrl.sv
hdl/fps_pnt_store.sv
hdl/fps_dist_calc.sv
hdl/fps_max_sel.sv
hdl/fps_top.sv
test/fps_asserts.sv
test/fps_tb.sv

// ==== hdl/fps_cfg_pkg.sv ====
package fps_cfg_pkg;

    // =========================================================================
    // Point geometry
    // =========================================================================

    // One unsigned coordinate
    localparam int CRD_WIDTH = 8;

    // x, y, z packed with x in the low bits
    localparam int CRD_DIM   = 3;
    localparam int PNT_WIDTH = CRD_WIDTH * CRD_DIM;

    // =========================================================================
    // Distances
    // =========================================================================

    // Sum of CRD_DIM squares of a coordinate difference
    localparam int DIST_WIDTH = 2 * CRD_WIDTH + $clog2(CRD_DIM);

    // Starting minimum, larger than any real distance
    localparam logic [DIST_WIDTH-1:0] DIST_MAX = '1;

endpackage

// ==== hdl/fps_ctrl.sv ====
module fps_ctrl #(
    parameter int max_pnt   = 32,
    parameter int idx_width = 5
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [idx_width:0]   cfg_nip,
    input  logic [idx_width:0]   cfg_nop,
    input  logic                 smp_vld,
    output logic                 clr,
    output logic                 rd_en,
    output logic [idx_width-1:0] rd_addr,
    output logic                 rd_seed,
    output logic                 rd_last,
    output logic                 busy,
    output logic                 done
);

    // Point count never exceeds the store capacity
    localparam logic [idx_width:0] nip_cap = (idx_width + 1)'(max_pnt);

    fps_ctrl_pkg::fps_state_e state;
    fps_ctrl_pkg::fps_state_e state_nxt;

    logic [idx_width:0]   nip_q;
    logic [idx_width:0]   nop_q;
    logic [idx_width-1:0] pnt_cnt;
    logic [idx_width:0]   smp_cnt;
    logic                 pnt_last;
    logic                 smp_final;

    // =========================================================================
    // State machine
    // =========================================================================

    assign clr       = start & (state == fps_ctrl_pkg::ST_IDLE);
    assign pnt_last  = ({1'b0, pnt_cnt} + 1'b1) == nip_q;
    assign smp_final = (smp_cnt + 1'b1) == nop_q;

    always_comb begin
        state_nxt = state;
        case (state)
            fps_ctrl_pkg::ST_IDLE: begin
                if (start) begin
                    state_nxt = fps_ctrl_pkg::ST_SEED;
                end
            end
            fps_ctrl_pkg::ST_SEED: state_nxt = fps_ctrl_pkg::ST_DRAIN;
            fps_ctrl_pkg::ST_LOOP: begin
                if (pnt_last) begin
                    state_nxt = fps_ctrl_pkg::ST_DRAIN;
                end
            end
            // Hold until the pass's sample leaves the pipeline
            fps_ctrl_pkg::ST_DRAIN: begin
                if (smp_vld) begin
                    state_nxt = smp_final ? fps_ctrl_pkg::ST_IDLE : fps_ctrl_pkg::ST_LOOP;
                end
            end
            default: state_nxt = fps_ctrl_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fps_ctrl_pkg::ST_IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= (state == fps_ctrl_pkg::ST_DRAIN) & smp_vld & smp_final;
        end
    end

    // =========================================================================
    // Configuration and counters
    // =========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nip_q   <= '0;
            nop_q   <= '0;
            pnt_cnt <= '0;
            smp_cnt <= '0;
        end else if (clr) begin
            nip_q   <= (cfg_nip > nip_cap) ? nip_cap : cfg_nip;
            nop_q   <= cfg_nop;
            pnt_cnt <= '0;
            smp_cnt <= '0;
        end else begin
            // Address wraps at the end of every loop pass
            if (state == fps_ctrl_pkg::ST_LOOP) begin
                pnt_cnt <= pnt_last ? '0 : pnt_cnt + 1'b1;
            end
            if (smp_vld) begin
                smp_cnt <= smp_cnt + 1'b1;
            end
        end
    end

    assign rd_en   = (state == fps_ctrl_pkg::ST_SEED) | (state == fps_ctrl_pkg::ST_LOOP);
    assign rd_addr = pnt_cnt;
    assign rd_seed = (state == fps_ctrl_pkg::ST_SEED);
    assign rd_last = (state == fps_ctrl_pkg::ST_LOOP) & pnt_last;
    assign busy    = (state != fps_ctrl_pkg::ST_IDLE);

endmodule

// ==== hdl/fps_ctrl_pkg.sv ====
package fps_ctrl_pkg;

    // Pass sequencing of the sampling controller
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_SEED  = 2'd1,
        ST_LOOP  = 2'd2,
        ST_DRAIN = 2'd3
    } fps_state_e;

endpackage

// ==== hdl/fps_dist_calc.sv ====
module fps_dist_calc #(
    parameter int idx_width = 5
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                q_vld,
    input  logic [idx_width-1:0]                q_idx,
    input  logic [fps_cfg_pkg::PNT_WIDTH-1:0]   q_crd,
    input  logic [fps_cfg_pkg::DIST_WIDTH-1:0]  q_dist,
    input  logic                                q_mask,
    input  logic                                q_seed,
    input  logic                                q_last,
    input  logic [fps_cfg_pkg::PNT_WIDTH-1:0]   ctr_crd,
    output logic                                d_vld,
    output logic [idx_width-1:0]                d_idx,
    output logic [fps_cfg_pkg::PNT_WIDTH-1:0]   d_crd,
    output logic [fps_cfg_pkg::DIST_WIDTH-1:0]  d_dist,
    output logic                                d_mask,
    output logic                                d_seed,
    output logic                                d_last
);

    logic [fps_cfg_pkg::DIST_WIDTH-1:0] dist_sq;
    logic [fps_cfg_pkg::DIST_WIDTH-1:0] dist_min;

    // Squared distance to the centre, one coordinate at a time
    always_comb begin
        logic [fps_cfg_pkg::CRD_WIDTH-1:0]   crd_a;
        logic [fps_cfg_pkg::CRD_WIDTH-1:0]   crd_b;
        logic [fps_cfg_pkg::CRD_WIDTH-1:0]   diff;
        logic [2*fps_cfg_pkg::CRD_WIDTH-1:0] sq;
        dist_sq = '0;
        for (int i = 0; i < fps_cfg_pkg::CRD_DIM; i++) begin
            crd_a   = q_crd[i*fps_cfg_pkg::CRD_WIDTH +: fps_cfg_pkg::CRD_WIDTH];
            crd_b   = ctr_crd[i*fps_cfg_pkg::CRD_WIDTH +: fps_cfg_pkg::CRD_WIDTH];
            diff    = (crd_a > crd_b) ? crd_a - crd_b : crd_b - crd_a;
            sq      = diff * diff;
            dist_sq = dist_sq + fps_cfg_pkg::DIST_WIDTH'(sq);
        end
    end

    // Nearest chosen sample so far
    assign dist_min = (dist_sq < q_dist) ? dist_sq : q_dist;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_vld  <= 1'b0;
            d_seed <= 1'b0;
            d_last <= 1'b0;
        end else begin
            d_vld  <= q_vld;
            d_seed <= q_vld & q_seed;
            d_last <= q_vld & q_last;
        end
    end

    always_ff @(posedge clk) begin
        if (q_vld) begin
            d_idx  <= q_idx;
            d_crd  <= q_crd;
            d_dist <= dist_min;
            d_mask <= q_mask;
        end
    end

endmodule

// ==== hdl/fps_max_sel.sv ====
module fps_max_sel #(
    parameter int idx_width = 5
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                d_vld,
    input  logic [idx_width-1:0]                d_idx,
    input  logic [fps_cfg_pkg::PNT_WIDTH-1:0]   d_crd,
    input  logic [fps_cfg_pkg::DIST_WIDTH-1:0]  d_dist,
    input  logic                                d_mask,
    input  logic                                d_seed,
    input  logic                                d_last,
    output logic                                wb_en,
    output logic [idx_width-1:0]                wb_idx,
    output logic [fps_cfg_pkg::DIST_WIDTH-1:0]  wb_dist,
    output logic                                smp_vld,
    output logic [idx_width-1:0]                smp_idx,
    output logic [fps_cfg_pkg::PNT_WIDTH-1:0]   smp_crd,
    output logic [fps_cfg_pkg::PNT_WIDTH-1:0]   ctr_crd
);

    logic                               best_vld;
    logic [idx_width-1:0]               best_idx;
    logic [fps_cfg_pkg::PNT_WIDTH-1:0]  best_crd;
    logic [fps_cfg_pkg::DIST_WIDTH-1:0] best_dist;
    logic                               take;

    // Seed read carries a stale centre, so only loop points write back
    assign wb_en   = d_vld & ~d_seed;
    assign wb_idx  = d_idx;
    assign wb_dist = d_dist;

    // Strictly larger wins, lowest index keeps ties
    assign take = d_vld & ~d_seed & ~d_mask & (~best_vld | (d_dist > best_dist));

    // =========================================================================
    // Running best and sample output
    // =========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_vld <= 1'b0;
            smp_vld  <= 1'b0;
        end else begin
            smp_vld <= d_vld & (d_seed | d_last);
            if (d_vld & d_last) begin
                best_vld <= 1'b0;
            end else if (take) begin
                best_vld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            best_idx  <= d_idx;
            best_crd  <= d_crd;
            best_dist <= d_dist;
        end
        if (d_vld & d_seed) begin
            smp_idx <= d_idx;
            smp_crd <= d_crd;
        end else if (d_vld & d_last) begin
            // Last point of the pass may itself be the farthest
            smp_idx <= take ? d_idx : best_idx;
            smp_crd <= take ? d_crd : best_crd;
        end
    end

    // Latest sample is the next pass's centre
    assign ctr_crd = smp_crd;

endmodule

// ==== hdl/fps_pnt_store.sv ====
module fps_pnt_store #(
    parameter int max_pnt   = 32,
    parameter int idx_width = 5
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                pt_wr,
    input  logic [idx_width-1:0]                pt_addr,
    input  logic [fps_cfg_pkg::PNT_WIDTH-1:0]   pt_crd,
    input  logic                                clr,
    input  logic                                rd_en,
    input  logic [idx_width-1:0]                rd_addr,
    input  logic                                rd_seed,
    input  logic                                rd_last,
    output logic                                q_vld,
    output logic [idx_width-1:0]                q_idx,
    output logic [fps_cfg_pkg::PNT_WIDTH-1:0]   q_crd,
    output logic [fps_cfg_pkg::DIST_WIDTH-1:0]  q_dist,
    output logic                                q_mask,
    output logic                                q_seed,
    output logic                                q_last,
    input  logic                                wb_en,
    input  logic [idx_width-1:0]                wb_idx,
    input  logic [fps_cfg_pkg::DIST_WIDTH-1:0]  wb_dist,
    input  logic                                smp_vld,
    input  logic [idx_width-1:0]                smp_idx
);

    logic [fps_cfg_pkg::PNT_WIDTH-1:0]  crd_mem  [max_pnt];
    logic [fps_cfg_pkg::DIST_WIDTH-1:0] dist_mem [max_pnt];
    logic [max_pnt-1:0]                 mask;

    // Host load port
    always_ff @(posedge clk) begin
        if (pt_wr) begin
            crd_mem[pt_addr] <= pt_crd;
        end
    end

    // Running minimum per point, reopened at every run
    always_ff @(posedge clk) begin
        if (clr) begin
            for (int i = 0; i < max_pnt; i++) begin
                dist_mem[i] <= fps_cfg_pkg::DIST_MAX;
            end
        end else if (wb_en) begin
            dist_mem[wb_idx] <= wb_dist;
        end
    end

    // Chosen points are masked out of later selections
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask <= '0;
        end else if (clr) begin
            mask <= '0;
        end else if (smp_vld) begin
            mask[smp_idx] <= 1'b1;
        end
    end

    // =========================================================================
    // Registered read port
    // =========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_vld  <= 1'b0;
            q_seed <= 1'b0;
            q_last <= 1'b0;
        end else begin
            q_vld  <= rd_en;
            q_seed <= rd_en & rd_seed;
            q_last <= rd_en & rd_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            q_idx  <= rd_addr;
            q_crd  <= crd_mem[rd_addr];
            q_dist <= dist_mem[rd_addr];
            q_mask <= mask[rd_addr];
        end
    end

endmodule

// ==== hdl/fps_top.sv ====
module fps_top #(
    parameter int max_pnt   = 32,
    parameter int idx_width = $clog2(max_pnt)
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              pt_wr,
    input  logic [idx_width-1:0]              pt_addr,
    input  logic [fps_cfg_pkg::PNT_WIDTH-1:0] pt_crd,
    input  logic                              start,
    input  logic [idx_width:0]                cfg_nip,
    input  logic [idx_width:0]                cfg_nop,
    output logic                              out_vld,
    output logic [idx_width-1:0]              out_idx,
    output logic [fps_cfg_pkg::PNT_WIDTH-1:0] out_crd,
    output logic                              busy,
    output logic                              done
);

    // Controller to store
    logic                 clr;
    logic                 rd_en;
    logic [idx_width-1:0] rd_addr;
    logic                 rd_seed;
    logic                 rd_last;

    // Store to distance stage
    logic                               q_vld;
    logic [idx_width-1:0]               q_idx;
    logic [fps_cfg_pkg::PNT_WIDTH-1:0]  q_crd;
    logic [fps_cfg_pkg::DIST_WIDTH-1:0] q_dist;
    logic                               q_mask;
    logic                               q_seed;
    logic                               q_last;

    // Distance stage to selector
    logic                               d_vld;
    logic [idx_width-1:0]               d_idx;
    logic [fps_cfg_pkg::PNT_WIDTH-1:0]  d_crd;
    logic [fps_cfg_pkg::DIST_WIDTH-1:0] d_dist;
    logic                               d_mask;
    logic                               d_seed;
    logic                               d_last;

    // Selector feedback
    logic                               wb_en;
    logic [idx_width-1:0]               wb_idx;
    logic [fps_cfg_pkg::DIST_WIDTH-1:0] wb_dist;
    logic                               smp_vld;
    logic [idx_width-1:0]               smp_idx;
    logic [fps_cfg_pkg::PNT_WIDTH-1:0]  smp_crd;
    logic [fps_cfg_pkg::PNT_WIDTH-1:0]  ctr_crd;

    fps_ctrl #(
        .max_pnt   (max_pnt),
        .idx_width (idx_width)
    ) ctrl_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .cfg_nip (cfg_nip),
        .cfg_nop (cfg_nop),
        .smp_vld (smp_vld),
        .clr     (clr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_seed (rd_seed),
        .rd_last (rd_last),
        .busy    (busy),
        .done    (done)
    );

    fps_pnt_store #(
        .max_pnt   (max_pnt),
        .idx_width (idx_width)
    ) store_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pt_wr   (pt_wr),
        .pt_addr (pt_addr),
        .pt_crd  (pt_crd),
        .clr     (clr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_seed (rd_seed),
        .rd_last (rd_last),
        .q_vld   (q_vld),
        .q_idx   (q_idx),
        .q_crd   (q_crd),
        .q_dist  (q_dist),
        .q_mask  (q_mask),
        .q_seed  (q_seed),
        .q_last  (q_last),
        .wb_en   (wb_en),
        .wb_idx  (wb_idx),
        .wb_dist (wb_dist),
        .smp_vld (smp_vld),
        .smp_idx (smp_idx)
    );

    fps_dist_calc #(
        .idx_width (idx_width)
    ) dist_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .q_vld   (q_vld),
        .q_idx   (q_idx),
        .q_crd   (q_crd),
        .q_dist  (q_dist),
        .q_mask  (q_mask),
        .q_seed  (q_seed),
        .q_last  (q_last),
        .ctr_crd (ctr_crd),
        .d_vld   (d_vld),
        .d_idx   (d_idx),
        .d_crd   (d_crd),
        .d_dist  (d_dist),
        .d_mask  (d_mask),
        .d_seed  (d_seed),
        .d_last  (d_last)
    );

    fps_max_sel #(
        .idx_width (idx_width)
    ) sel_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .d_vld   (d_vld),
        .d_idx   (d_idx),
        .d_crd   (d_crd),
        .d_dist  (d_dist),
        .d_mask  (d_mask),
        .d_seed  (d_seed),
        .d_last  (d_last),
        .wb_en   (wb_en),
        .wb_idx  (wb_idx),
        .wb_dist (wb_dist),
        .smp_vld (smp_vld),
        .smp_idx (smp_idx),
        .smp_crd (smp_crd),
        .ctr_crd (ctr_crd)
    );

    // Samples leave straight from the selector registers
    assign out_vld = smp_vld;
    assign out_idx = smp_idx;
    assign out_crd = smp_crd;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the log
rm -rf obj_dir sim.log \
    && verilator --binary --timing --assert --top-module fps_tb -f filelist.f -o fps_sim \
    && ./obj_dir/fps_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^=== PASS ===$" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== test/fps_asserts.sv ====
module fps_asserts (
    input logic clk,
    input logic rst_n,
    input logic pt_wr,
    input logic out_vld,
    input logic busy,
    input logic done
);

    // Samples only leave while a run is active
    out_vld_in_run: assert property (@(posedge clk) disable iff (!rst_n) out_vld |-> busy)
        else $error("out_vld seen while the engine is not busy");

    // End of run is a single pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done held high for more than one cycle");

    // busy falls together with done
    done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else $error("busy still high while done pulses");

    // Host loads points only between runs
    no_load_in_run: assert property (@(posedge clk) disable iff (!rst_n) pt_wr |-> !busy)
        else $error("point write issued while the engine is busy");

endmodule

bind fps_top fps_asserts asserts_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .pt_wr   (pt_wr),
    .out_vld (out_vld),
    .busy    (busy),
    .done    (done)
);

// ==== test/fps_tb.sv ====
module fps_tb;

    localparam int MAX_PNT   = 32;
    localparam int IDX_W     = $clog2(MAX_PNT);
    localparam int NUM_CASES = 7;

    localparam int MODE_LCG   = 0;
    localparam int MODE_EQUAL = 1;
    localparam int MODE_FIXED = 2;

    localparam logic [23:0] EQUAL_PT = 24'h3c5a7e;

    logic                 clk;
    logic                 rst_n;
    logic                 pt_wr;
    logic [IDX_W-1:0]     pt_addr;
    logic [23:0]          pt_crd;
    logic                 start;
    logic [IDX_W:0]       cfg_nip;
    logic [IDX_W:0]       cfg_nop;
    logic                 out_vld;
    logic [IDX_W-1:0]     out_idx;
    logic [23:0]          out_crd;
    logic                 busy;
    logic                 done;

    // Each row holds nip, nop, point mode and an extra start while busy
    int case_tbl [NUM_CASES][4] = '{
        '{16,  6, MODE_LCG,   0},
        '{32, 10, MODE_LCG,   1},
        '{ 8,  8, MODE_EQUAL, 0},
        '{12, 12, MODE_LCG,   0},
        '{10,  1, MODE_LCG,   0},
        '{ 6,  6, MODE_FIXED, 0},
        '{ 1,  1, MODE_LCG,   0}
    };

    logic [23:0] pts [MAX_PNT];
    int          exp_idx [MAX_PNT];
    int unsigned lcg_state = 51;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;

    fps_top #(
        .max_pnt (MAX_PNT)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pt_wr   (pt_wr),
        .pt_addr (pt_addr),
        .pt_crd  (pt_crd),
        .start   (start),
        .cfg_nip (cfg_nip),
        .cfg_nop (cfg_nop),
        .out_vld (out_vld),
        .out_idx (out_idx),
        .out_crd (out_crd),
        .busy    (busy),
        .done    (done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    function automatic logic [23:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:8];
    endfunction

    // Hand-made layout with a distance tie between points 1 and 2
    function automatic logic [23:0] fixed_point(input int i);
        case (i)
            0:       return 24'h000000;
            1:       return 24'h000010;
            2:       return 24'h001000;
            3:       return 24'h202020;
            4:       return 24'hff0000;
            5:       return 24'h0000ff;
            default: return 24'h808080;
        endcase
    endfunction

    function automatic int sq_dist(input logic [23:0] a, input logic [23:0] b);
        int sum;
        int diff;
        sum = 0;
        for (int k = 0; k < 3; k++) begin
            diff = int'(a[k*8 +: 8]) - int'(b[k*8 +: 8]);
            sum = sum + diff * diff;
        end
        return sum;
    endfunction

    // Expected samples take the largest minimum distance and the lowest index on ties
    function automatic void ref_samples(input int nip, input int nop);
        int min_d [MAX_PNT];
        bit chosen [MAX_PNT];
        int ctr;
        int best;
        for (int i = 0; i < MAX_PNT; i++) begin
            min_d[i] = 32'h7fff_ffff;
            chosen[i] = 1'b0;
        end
        exp_idx[0] = 0;
        chosen[0] = 1'b1;
        ctr = 0;
        for (int s = 1; s < nop; s++) begin
            best = -1;
            for (int i = 0; i < nip; i++) begin
                if (sq_dist(pts[i], pts[ctr]) < min_d[i]) begin
                    min_d[i] = sq_dist(pts[i], pts[ctr]);
                end
                if (!chosen[i] && (best < 0 || min_d[i] > min_d[best])) begin
                    best = i;
                end
            end
            exp_idx[s] = best;
            chosen[best] = 1'b1;
            ctr = best;
        end
    endfunction

    function automatic int cycle_limit();
        int sum;
        sum = 0;
        for (int c = 0; c < NUM_CASES; c++) begin
            sum = sum + case_tbl[c][1] * (case_tbl[c][0] + 8) + case_tbl[c][0] + 4;
        end
        return sum + 100;
    endfunction

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERR %0t: %s", $time, msg);
        end
    endtask

    // Inputs change a little after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic load_points(input int nip);
        for (int i = 0; i < nip; i++) begin
            pt_wr   = 1'b1;
            pt_addr = IDX_W'(i);
            pt_crd  = pts[i];
            tick();
            check(!busy && !done && !out_vld, $sformatf("engine active while idle, point %0d", i));
        end
        pt_wr = 1'b0;
    endtask

    // ========================================================================
    // One table row
    // ========================================================================

    task automatic run_case(input int c);
        int nip;
        int nop;
        int mode;
        int got;
        logic [MAX_PNT-1:0] seen;
        nip  = case_tbl[c][0];
        nop  = case_tbl[c][1];
        mode = case_tbl[c][2];
        for (int i = 0; i < nip; i++) begin
            if (mode == MODE_LCG) begin
                pts[i] = lcg_next();
            end else if (mode == MODE_EQUAL) begin
                pts[i] = EQUAL_PT;
            end else begin
                pts[i] = fixed_point(i);
            end
        end
        load_points(nip);
        ref_samples(nip, nop);

        start   = 1'b1;
        cfg_nip = (IDX_W + 1)'(nip);
        cfg_nop = (IDX_W + 1)'(nop);
        tick();
        start = 1'b0;
        check(busy, $sformatf("case %0d busy low after start", c));

        got  = 0;
        seen = '0;
        while (!done) begin
            tick();
            start = 1'b0;
            if (out_vld) begin
                check(got < nop, $sformatf("case %0d extra sample %0d", c, got));
                if (got < nop) begin
                    check(int'(out_idx) == exp_idx[got] && out_crd == pts[exp_idx[got]],
                          $sformatf("case %0d sample %0d got idx %0d crd %h, expected idx %0d",
                                    c, got, out_idx, out_crd, exp_idx[got]));
                end
                if (got == 0) begin
                    check(out_idx == '0 && out_crd == pts[0],
                          $sformatf("case %0d first sample is idx %0d", c, out_idx));
                end
                if (mode == MODE_EQUAL) begin
                    check(int'(out_idx) == got,
                          $sformatf("case %0d equal points, sample %0d is idx %0d",
                                    c, got, out_idx));
                end
                check(!seen[out_idx], $sformatf("case %0d idx %0d sampled twice", c, out_idx));
                seen[out_idx] = 1'b1;
                got++;
                // A second start in mid run must change nothing
                if (case_tbl[c][3] != 0 && got == 1) begin
                    start   = 1'b1;
                    cfg_nip = (IDX_W + 1)'(4);
                    cfg_nop = (IDX_W + 1)'(2);
                end
            end
        end
        check(got == nop, $sformatf("case %0d got %0d samples, expected %0d", c, got, nop));
        if (nop == nip) begin
            check($countones(seen) == nip,
                  $sformatf("case %0d covered %0d of %0d indices", c, $countones(seen), nip));
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        pt_wr   = 1'b0;
        pt_addr = '0;
        pt_crd  = '0;
        start   = 1'b0;
        cfg_nip = '0;
        cfg_nop = '0;
        limit   = cycle_limit();

        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (3) begin
            tick();
            check(!busy && !done && !out_vld, "outputs not idle after reset");
        end

        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
